// ==== logic/rgmii_rx_defs.svh ====
// widths and offsets assume a 32-bit APB data bus and byte addressing, so offsets step by 4

`ifndef RGMII_RX_DEFS_SVH
`define RGMII_RX_DEFS_SVH

// four RGMII data lines plus the control line
`define RX_DDR_WIDTH 5

// APB address and data widths
`define APB_ADDR_WIDTH 8
// counters and prdata share one width
`define CNT_WIDTH 32

// register map, word aligned
`define REG_ID_STATUS 8'h00
`define REG_FRAMES 8'h04
`define REG_BYTES 8'h08
`define REG_ERRORS 8'h0C
`define REG_LAST_LEN 8'h10
`define REG_CTRL 8'h14

// fixed id in the upper half of REG_ID_STATUS ("RG")
`define RX_ID 16'h5247

`endif

// ==== logic/rgmii_rx_pkg.sv ====
// in-band status layout follows the RGMII idle encoding, only the low nibble of the byte is decoded
`default_nettype none

package rgmii_rx_pkg;

    // link speed code as sent by the PHY in bits 2:1 of the idle nibble
    typedef enum logic [1:0] {
        SPEED_10   = 2'b00,
        SPEED_100  = 2'b01,
        SPEED_1000 = 2'b10
    } speed_e;

    // in-band status nibble, msb first
    // bit 3 duplex, bits 2:1 speed, bit 0 link
    typedef struct packed {
        logic   full_duplex;
        speed_e speed;
        logic   link_up;
    } inband_status_t;

    // upper nibble of an idle byte, repeats the status on most PHYs
    typedef struct packed {
        logic [3:0]     upper;
        inband_status_t status;
    } inband_word_t;

    // one received byte
    // raw view inside a frame, inband view between frames
    typedef union packed {
        logic [7:0]   raw;
        inband_word_t inband;
    } rx_word_u;

endpackage

`default_nettype wire

// ==== logic/rx_byte_if.sv ====
// no handshake on this link, the sink must take one event in every cycle
`timescale 1ns/1ps
`default_nettype none

interface rx_byte_if;
    import rgmii_rx_pkg::*;

    // one byte inside a frame
    logic           valid;
    rx_word_u       data;
    // first byte of a frame, qualifies valid
    logic           frame_start;
    // pulse on the first idle cycle after a frame
    logic           frame_end;
    // frame had an error byte, only with frame_end
    logic           frame_err;
    // last in-band status seen between frames
    inband_status_t status;
    // pulse when status changes
    logic           status_upd;

    // decoder side
    modport src (
        output valid, data, frame_start, frame_end, frame_err, status, status_upd
    );

    // register block side
    modport dst (
        input valid, data, frame_start, frame_end, frame_err, status, status_upd
    );

endinterface

`default_nettype wire

// ==== logic/ddr_iddr.sv ====
// generic fabric flops only, no vendor primitive and no reset since clk is the forwarded clock
`timescale 1ns/1ps
`default_nettype none

module ddr_iddr #(
    parameter int WIDTH = 1
) (
    input  wire logic             clk,
    input  wire logic [WIDTH-1:0] d,
    output logic      [WIDTH-1:0] q1,
    output logic      [WIDTH-1:0] q2
);

    // sample taken on the rising edge
    logic [WIDTH-1:0] d_rise;
    // sample taken on the falling edge
    logic [WIDTH-1:0] d_fall;

    // first half of the cycle
    always_ff @(posedge clk) begin
        d_rise <= d;
    end

    // second half, mid cycle
    always_ff @(negedge clk) begin
        d_fall <= d;
    end

    // re-time both halves onto the next rising edge
    // so q1/q2 always hold a matched pair from one cycle
    always_ff @(posedge clk) begin
        q1 <= d_rise;
        q2 <= d_fall;
    end

endmodule

`default_nettype wire

// ==== logic/ssio_ddr_in.sv ====
// generic clock path only, no BUFIO/BUFR or BUFG, the forwarded clock drives the logic directly
`timescale 1ns/1ps
`default_nettype none

`include "rgmii_rx_defs.svh"

module ssio_ddr_in (
    input  wire logic                     input_clk,
    input  wire logic [`RX_DDR_WIDTH-1:0] input_d,
    output logic                          output_clk,
    output logic      [`RX_DDR_WIDTH-1:0] output_q1,
    output logic      [`RX_DDR_WIDTH-1:0] output_q2
);

    // clock feeding the capture flops
    logic clk_io;
    // clock handed on to the logic behind
    logic clk_int;

    // capture flops run straight off the pin clock
    assign clk_io = input_clk;

    // logic clock is the same net, no divide
    assign clk_int = input_clk;
    assign output_clk = clk_int;

    // all five lines share one DDR register
    // rising half on q1, falling half on q2
    ddr_iddr #(
        .WIDTH(`RX_DDR_WIDTH)
    ) u_data_iddr (
        .clk(clk_io),
        .d  (input_d),
        .q1 (output_q1),
        .q2 (output_q2)
    );

endmodule

`default_nettype wire

// ==== logic/rgmii_rx_decode.sv ====
// assumes at least one idle cycle between frames, back-to-back frames are merged into one
`timescale 1ns/1ps
`default_nettype none

`include "rgmii_rx_defs.svh"

module rgmii_rx_decode (
    input  wire logic                     output_clk,
    input  wire logic                     rst_n,
    input  wire logic [`RX_DDR_WIDTH-1:0] q1,
    input  wire logic [`RX_DDR_WIDTH-1:0] q2,
    rx_byte_if.src                        rx
);
    import rgmii_rx_pkg::*;

    // control line sits above the data nibble
    localparam int CTL_BIT = `RX_DDR_WIDTH - 1;

    // byte view of the current nibble pair
    rx_word_u       word;
    // data valid from the rising sample
    logic           dv;
    // error is the xor of both control samples
    logic           err;
    // both control samples low, byte carries in-band status
    logic           idle;
    // status decoded from the idle byte
    inband_status_t new_status;
    // a frame is open
    logic           in_frame;
    // some byte of the open frame had error set
    logic           err_acc;

    // low nibble on the rising edge, high nibble on the falling edge
    always_comb begin
        word.raw = {q2[3:0], q1[3:0]};
    end

    assign dv         = q1[CTL_BIT];
    assign err        = q1[CTL_BIT] ^ q2[CTL_BIT];
    assign idle       = ~dv & ~err;
    assign new_status = word.inband.status;

    // payload, no reset needed
    always_ff @(posedge output_clk) begin
        rx.data <= word;
    end

    always_ff @(posedge output_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx.valid       <= 1'b0;
            rx.frame_start <= 1'b0;
            rx.frame_end   <= 1'b0;
            rx.frame_err   <= 1'b0;
            in_frame       <= 1'b0;
            err_acc        <= 1'b0;
        end else begin
            rx.valid       <= dv;
            // rising dv opens a frame
            rx.frame_start <= dv & ~in_frame;
            // first cycle without dv closes it
            rx.frame_end   <= ~dv & in_frame;
            // err_acc already holds the last byte here
            rx.frame_err   <= ~dv & in_frame & err_acc;
            in_frame       <= dv;
            if (dv) begin
                // restart the error flag on the first byte
                err_acc <= (in_frame & err_acc) | err;
            end else begin
                err_acc <= 1'b0;
            end
        end
    end

    // in-band status, only refreshed between frames
    always_ff @(posedge output_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx.status     <= '0;
            rx.status_upd <= 1'b0;
        end else begin
            rx.status_upd <= 1'b0;
            // carrier extend and false carrier bytes are skipped
            if (idle && new_status != rx.status) begin
                rx.status     <= new_status;
                rx.status_upd <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rx_stats_apb.sv ====
// zero wait state APB on output_clk, counters wrap silently and only REG_CTRL is writable
`timescale 1ns/1ps
`default_nettype none

`include "rgmii_rx_defs.svh"

module rx_stats_apb (
    input  wire logic                       output_clk,
    input  wire logic                       rst_n,
    rx_byte_if.dst                          rx,
    input  wire logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  wire logic                       psel,
    input  wire logic                       penable,
    input  wire logic                       pwrite,
    input  wire logic [`CNT_WIDTH-1:0]      pwdata,
    output logic      [`CNT_WIDTH-1:0]      prdata,
    output logic                            pready,
    output logic                            pslverr
);
    import rgmii_rx_pkg::*;

    localparam int CW = `CNT_WIDTH;

    // statistics counters
    logic [CW-1:0]  frame_cnt;
    logic [CW-1:0]  byte_cnt;
    logic [CW-1:0]  err_cnt;
    logic [CW-1:0]  last_len;
    // length of the frame in progress
    logic [CW-1:0]  cur_len;
    // latched in-band status
    inband_status_t status_q;
    // APB access phase
    logic           access;
    // paddr maps to a register
    logic           addr_hit;
    logic [CW-1:0]  rd_data;
    // counter clear strobe from REG_CTRL bit 0
    logic           clear;

    assign access = psel & penable;
    assign clear  = access & pwrite & (paddr == `REG_CTRL) & pwdata[0];

    // address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr)
            `REG_ID_STATUS: begin
                rd_data[CW-1 -: 16] = `RX_ID;
                rd_data[3:0]        = status_q;
            end
            `REG_FRAMES:   rd_data = frame_cnt;
            `REG_BYTES:    rd_data = byte_cnt;
            `REG_ERRORS:   rd_data = err_cnt;
            `REG_LAST_LEN: rd_data = last_len;
            // clear bit is self clearing, reads back zero
            `REG_CTRL:     rd_data = '0;
            default:       addr_hit = 1'b0;
        endcase
    end

    // no wait states
    assign pready  = access;
    assign prdata  = (psel & ~pwrite) ? rd_data : '0;
    // unmapped offset, or write to a read-only register
    assign pslverr = access & (~addr_hit | (pwrite & (paddr != `REG_CTRL)));

    // counters, clear beats a same-cycle frame event
    always_ff @(posedge output_clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            byte_cnt  <= '0;
            err_cnt   <= '0;
            last_len  <= '0;
            cur_len   <= '0;
        end else if (clear) begin
            frame_cnt <= '0;
            byte_cnt  <= '0;
            err_cnt   <= '0;
            last_len  <= '0;
            cur_len   <= '0;
        end else begin
            if (rx.valid) begin
                byte_cnt <= byte_cnt + 1'b1;
                // first byte restarts the length
                cur_len  <= rx.frame_start ? {{(CW-1){1'b0}}, 1'b1} : cur_len + 1'b1;
            end
            // frame counted once it has closed
            if (rx.frame_end) begin
                frame_cnt <= frame_cnt + 1'b1;
                last_len  <= cur_len;
            end
            if (rx.frame_err) begin
                err_cnt <= err_cnt + 1'b1;
            end
        end
    end

    // status is not a counter, the clear leaves it alone
    always_ff @(posedge output_clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= '0;
        end else if (rx.status_upd) begin
            status_q <= rx.status;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rgmii_rx_top.sv ====
// one clock domain, the APB host must run on output_clk forwarded from the PHY
`timescale 1ns/1ps
`default_nettype none

`include "rgmii_rx_defs.svh"

module rgmii_rx_top (
    // PHY side
    input  wire logic                       input_clk,
    input  wire logic [3:0]                 rxd,
    input  wire logic                       rx_ctl,
    // logic clock, same as input_clk
    output logic                            output_clk,
    input  wire logic                       rst_n,
    // APB slave
    input  wire logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  wire logic                       psel,
    input  wire logic                       penable,
    input  wire logic                       pwrite,
    input  wire logic [`CNT_WIDTH-1:0]      pwdata,
    output logic      [`CNT_WIDTH-1:0]      prdata,
    output logic                            pready,
    output logic                            pslverr
);

    // control above the data nibble
    logic [`RX_DDR_WIDTH-1:0] input_d;
    // rising and falling samples, aligned
    logic [`RX_DDR_WIDTH-1:0] q1;
    logic [`RX_DDR_WIDTH-1:0] q2;

    assign input_d = {rx_ctl, rxd};

    // decoder to register block
    rx_byte_if rx_bus ();

    ssio_ddr_in u_ssio_ddr_in (
        .input_clk (input_clk),
        .input_d   (input_d),
        .output_clk(output_clk),
        .output_q1 (q1),
        .output_q2 (q2)
    );

    rgmii_rx_decode u_rgmii_rx_decode (
        .output_clk(output_clk),
        .rst_n     (rst_n),
        .q1        (q1),
        .q2        (q2),
        .rx        (rx_bus.src)
    );

    rx_stats_apb u_rx_stats_apb (
        .output_clk(output_clk),
        .rst_n     (rst_n),
        .rx        (rx_bus.dst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

endmodule

`default_nettype wire

// ==== verif/rgmii_rx_sva.sv ====
// bound into rx_stats_apb, all checks except the reset one are off while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module rgmii_rx_sva (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic psel,
    input wire logic penable,
    input wire logic pready,
    input wire logic pslverr,
    input wire logic valid,
    input wire logic frame_start,
    input wire logic frame_end,
    input wire logic frame_err,
    input wire logic status_upd
);

    // number of assertion failures so far
    int fail_count = 0;

    // zero wait states, so pready only shows in the access phase
    a_pready_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable))
        else begin
            $error("pready high outside an APB access phase");
            fail_count++;
        end

    // an error response is still a completed transfer
    a_slverr_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> pready)
        else begin
            $error("pslverr high without pready");
            fail_count++;
        end

    // frame_end is the first idle cycle, never a data cycle
    a_end_not_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !(frame_end && valid))
        else begin
            $error("frame_end and valid in the same cycle");
            fail_count++;
        end

    a_err_with_end: assert property (@(posedge clk) disable iff (!rst_n)
        frame_err |-> frame_end)
        else begin
            $error("frame_err without frame_end");
            fail_count++;
        end

    // first edge after reset release, everything still quiet
    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !(pready || pslverr || valid || frame_start
                           || frame_end || frame_err || status_upd))
        else begin
            $error("output active in the first cycle after reset");
            fail_count++;
        end

endmodule

bind rx_stats_apb rgmii_rx_sva u_rgmii_rx_sva (
    .clk        (output_clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .pslverr    (pslverr),
    .valid      (rx.valid),
    .frame_start(rx.frame_start),
    .frame_end  (rx.frame_end),
    .frame_err  (rx.frame_err),
    .status_upd (rx.status_upd)
);

`default_nettype wire

// ==== verif/rgmii_rx_tb.sv ====
// each DDR half is launched on the edge before the one that captures it, run is cut at a cycle limit
`timescale 1ns/1ps
`default_nettype none

`include "rgmii_rx_defs.svh"

module rgmii_rx_tb;
    import rgmii_rx_pkg::*;

    localparam int NUM_BURSTS = 4;
    localparam int BURST_FRAMES = 10;
    // longest frame plus longest gap for every frame, plus the APB phases
    localparam int CYCLE_LIMIT = NUM_BURSTS * BURST_FRAMES * (64 + 20) + 2000;

    logic                       input_clk;
    logic                       output_clk;
    logic                       rst_n;
    logic [3:0]                 rxd;
    logic                       rx_ctl;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`CNT_WIDTH-1:0]      pwdata;
    logic [`CNT_WIDTH-1:0]      prdata;
    logic                       pready;
    logic                       pslverr;

    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    // failures of the bound assertions
    int     sva_fails;
    // reference model state
    int             m_frames;
    int             m_bytes;
    int             m_errors;
    int             m_last_len;
    inband_status_t m_status;

    rgmii_rx_top u_rgmii_rx_top (
        .input_clk (input_clk),
        .rxd       (rxd),
        .rx_ctl    (rx_ctl),
        .output_clk(output_clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        input_clk = 1'b0;
        forever #2 input_clk = ~input_clk;
    end

    // one byte on the wire
    // low nibble and dv ahead of the rising edge, high nibble and dv^er ahead of the falling one
    task automatic send_pair(input logic [3:0] lo, input logic [3:0] hi,
                             input logic ctl_rise, input logic ctl_fall);
        @(negedge input_clk);
        rxd    <= lo;
        rx_ctl <= ctl_rise;
        @(posedge input_clk);
        rxd    <= hi;
        rx_ctl <= ctl_fall;
    endtask

    // 1 to 64 random bytes, at most one of them marked bad
    task automatic send_frame(input logic with_err);
        int         len;
        int         err_pos;
        logic [7:0] b;
        len     = ({$random(seed)} % 64) + 1;
        err_pos = with_err ? ({$random(seed)} % len) : -1;
        for (int i = 0; i < len; i++) begin
            b = $random(seed);
            // bad byte keeps dv on the rising edge, dv xor er drops on the falling edge
            send_pair(b[3:0], b[7:4], 1'b1, (i == err_pos) ? 1'b0 : 1'b1);
        end
        m_frames   = m_frames + 1;
        m_bytes    = m_bytes + len;
        m_last_len = len;
        if (with_err) begin
            m_errors = m_errors + 1;
        end
    endtask

    // idle gap of 8 to 20 cycles carrying one random in-band status
    task automatic send_gap();
        int             n;
        inband_status_t st;
        n              = 8 + ({$random(seed)} % 13);
        st.link_up     = $random(seed);
        st.speed       = speed_e'({$random(seed)} % 3);
        st.full_duplex = $random(seed);
        for (int i = 0; i < n; i++) begin
            send_pair(st, st, 1'b0, 1'b0);
        end
        m_status = st;
    endtask

    // one APB transfer, setup then access, sampled mid cycle once pready is up
    task automatic apb_access(input logic wr, input logic [`APB_ADDR_WIDTH-1:0] addr,
                              input logic [`CNT_WIDTH-1:0] wdata,
                              output logic [`CNT_WIDTH-1:0] rdata, output logic err);
        @(posedge output_clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge output_clk);
        penable <= 1'b1;
        @(negedge output_clk);
        while (!pready) begin
            @(negedge output_clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge output_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [`APB_ADDR_WIDTH-1:0] addr,
                             input logic [`CNT_WIDTH-1:0] exp);
        logic [`CNT_WIDTH-1:0] got;
        logic                  err;
        apb_access(1'b0, addr, '0, got, err);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
        end
        if (err !== 1'b0) begin
            errors = errors + 1;
            $display("[FAIL] %0t pslverr on %s expected 0 got %b", $time, name, err);
        end
    endtask

    // illegal access, must answer with pslverr
    task automatic expect_slverr(input string name, input logic wr,
                                 input logic [`APB_ADDR_WIDTH-1:0] addr);
        logic [`CNT_WIDTH-1:0] rd;
        logic                  err;
        apb_access(wr, addr, 32'hffff_ffff, rd, err);
        checks = checks + 1;
        if (err !== 1'b1) begin
            errors = errors + 1;
            $display("[FAIL] %0t pslverr on %s expected 1 got %b", $time, name, err);
        end
    endtask

    task automatic compare_model();
        // status nibble is duplex, speed, link from msb down
        check_reg("id_status", `REG_ID_STATUS, {`RX_ID, 12'h000, m_status});
        check_reg("frames", `REG_FRAMES, m_frames);
        check_reg("bytes", `REG_BYTES, m_bytes);
        check_reg("errors", `REG_ERRORS, m_errors);
        check_reg("last_len", `REG_LAST_LEN, m_last_len);
    endtask

    initial begin
        seed       = 32'hc05e16c2;
        errors     = 0;
        checks     = 0;
        m_frames   = 0;
        m_bytes    = 0;
        m_errors   = 0;
        m_last_len = 0;
        m_status   = '0;
        rst_n      = 1'b0;
        rxd        = 4'h0;
        rx_ctl     = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        repeat (2) @(posedge input_clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge input_clk);
        compare_model();
        for (int b = 0; b < NUM_BURSTS; b++) begin
            // about one frame in four carries a bad byte
            for (int f = 0; f < BURST_FRAMES; f++) begin
                send_frame(({$random(seed)} % 4) == 0);
                send_gap();
            end
            compare_model();
            if (b == 1) begin
                expect_slverr("unmapped read", 1'b0, 8'h18);
                expect_slverr("unaligned read", 1'b0, 8'h02);
                expect_slverr("frames write", 1'b1, `REG_FRAMES);
                expect_slverr("bytes write", 1'b1, `REG_BYTES);
                compare_model();
                expect_slverr("id_status write", 1'b1, `REG_ID_STATUS);
                check_reg("ctrl", `REG_CTRL, '0);
                expect_slverr("last_len write", 1'b1, `REG_LAST_LEN);
                // counters restart from zero, the status stays
                begin : clear_counters
                    logic [`CNT_WIDTH-1:0] rd;
                    logic                  err;
                    apb_access(1'b1, `REG_CTRL, 32'h1, rd, err);
                    if (err !== 1'b0) begin
                        errors = errors + 1;
                        $display("[FAIL] %0t pslverr on ctrl write expected 0 got %b",
                                 $time, err);
                    end
                end
                m_frames   = 0;
                m_bytes    = 0;
                m_errors   = 0;
                m_last_len = 0;
                compare_model();
            end
        end
        sva_fails = u_rgmii_rx_top.u_rx_stats_apb.u_rgmii_rx_sva.fail_count;
        $display("checks %0d errors %0d assertion failures %0d", checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge input_clk);
            cycles = cycles + 1;
        end
        $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/rgmii_rx_pkg.sv
logic/rx_byte_if.sv
logic/ddr_iddr.sv
logic/ssio_ddr_in.sv
logic/rgmii_rx_decode.sv
logic/rx_stats_apb.sv
logic/rgmii_rx_top.sv
verif/rgmii_rx_sva.sv
verif/rgmii_rx_tb.sv
